// File: verilog/ft_alu_pkg.sv
// XLEN is fixed at 32 and the 4-bit opcode space leaves six codes unused, which replicas treat as nop
package ft_alu_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	// operand and result width
	localparam int unsigned XLEN         = 32;
	// replicas built into the stage
	localparam int unsigned NUM_REPLICAS = 4;
	// lanes feeding each majority voter
	localparam int unsigned NUM_LANES    = 3;
	// the replica that can stand in for any lane
	localparam int unsigned SPARE_REPLICA = NUM_REPLICAS - 1;

	////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// request and result bundles
	////////////////////////////////////////////////////////////

	// one request per replica, enable is a plain level
	typedef struct packed {
		logic            enable;
		alu_op_e         op;
		logic [XLEN-1:0] operand_a;
		logic [XLEN-1:0] operand_b;
	} alu_req_t;

	// single-bit outputs, voted together
	typedef struct packed {
		logic cmp;
		logic valid;
	} alu_flags_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		alu_flags_t      flags;
	} alu_out_t;

	// 0 keeps lanes 0..2 on replicas 0..2
	// 1..3 puts the spare replica on lane 0..2
	typedef logic [1:0] spare_sel_t;

endpackage

// File: verilog/alu_replica.sv
// One ALU copy with a single registered output stage and no stall input, so a result is lost if not consumed the next cycle
`timescale 1ns/1ps

module alu_replica (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  ft_alu_pkg::alu_req_t req_i,
	output ft_alu_pkg::alu_out_t out_o
);

	import ft_alu_pkg::*;

	// shift amount, low five bits of operand b
	logic [4:0]      shamt;
	// comparisons shared by slt, sltu and cmp
	logic            lt_signed;
	logic            lt_unsigned;
	logic            operands_eq;
	// next-state values for the output register
	logic [XLEN-1:0] result_d;
	logic            cmp_d;
	alu_out_t        out_q;

	assign shamt       = req_i.operand_b[4:0];
	assign lt_signed   = $signed(req_i.operand_a) < $signed(req_i.operand_b);
	assign lt_unsigned = req_i.operand_a < req_i.operand_b;
	assign operands_eq = req_i.operand_a == req_i.operand_b;

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	always_comb begin
		result_d = '0;
		// equality unless the op is a less-than
		cmp_d    = operands_eq;
		case (req_i.op)
			ALU_ADD:  result_d = req_i.operand_a + req_i.operand_b;
			ALU_SUB:  result_d = req_i.operand_a - req_i.operand_b;
			ALU_AND:  result_d = req_i.operand_a & req_i.operand_b;
			ALU_OR:   result_d = req_i.operand_a | req_i.operand_b;
			ALU_XOR:  result_d = req_i.operand_a ^ req_i.operand_b;
			ALU_SLL:  result_d = req_i.operand_a << shamt;
			ALU_SRL:  result_d = req_i.operand_a >> shamt;
			// arithmetic shift keeps the sign
			ALU_SRA:  result_d = $unsigned($signed(req_i.operand_a) >>> shamt);
			ALU_SLT: begin
				result_d = {{(XLEN-1){1'b0}}, lt_signed};
				cmp_d    = lt_signed;
			end
			ALU_SLTU: begin
				result_d = {{(XLEN-1){1'b0}}, lt_unsigned};
				cmp_d    = lt_unsigned;
			end
			// unused codes give zero
			default:  result_d = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// an idle replica holds all zero so idle lanes agree in the voter
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_q <= '0;
		end else if (!req_i.enable) begin
			out_q <= '0;
		end else begin
			out_q.result      <= result_d;
			out_q.flags.cmp   <= cmp_d;
			out_q.flags.valid <= 1'b1;
		end
	end

	assign out_o = out_q;

	// valid is the enable of one cycle earlier
	a_valid_follows_enable: assert property (
		@(posedge clk) rst_n_i |=> (out_o.flags.valid == $past(req_i.enable))
	) else $error("replica valid does not follow last enable");

endmodule

// File: verilog/replica_select.sv
// Purely combinational and a single spare only, so at most one lane can be moved onto the spare replica
`timescale 1ns/1ps

module replica_select (
	input  ft_alu_pkg::alu_out_t [ft_alu_pkg::NUM_REPLICAS-1:0] replica_out_i,
	input  ft_alu_pkg::spare_sel_t                              spare_sel_i,
	input  logic [ft_alu_pkg::NUM_LANES-1:0]                    lane_err_i,
	output ft_alu_pkg::alu_out_t [ft_alu_pkg::NUM_LANES-1:0]    lane_out_o,
	output logic [ft_alu_pkg::NUM_REPLICAS-1:0]                 replica_err_o
);

	import ft_alu_pkg::*;

	// one-hot-or-zero view of the spare selector
	logic [NUM_LANES-1:0] lane_is_spare;

	////////////////////////////////////////////////////////////
	// replicas to lanes
	////////////////////////////////////////////////////////////

	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		// selector value k+1 names lane k
		assign lane_is_spare[k] = (spare_sel_i == spare_sel_t'(k + 1));
		// lane k normally reads replica k
		assign lane_out_o[k] = lane_is_spare[k] ? replica_out_i[SPARE_REPLICA]
		                                        : replica_out_i[k];
	end

	////////////////////////////////////////////////////////////
	// lane errors back to replicas
	////////////////////////////////////////////////////////////

	// same map in reverse
	// a replica that feeds no lane stays clear
	always_comb begin
		replica_err_o = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			if (lane_is_spare[k]) begin
				replica_err_o[SPARE_REPLICA] = lane_err_i[k];
			end else begin
				replica_err_o[k] = lane_err_i[k];
			end
		end
	end

endmodule

// File: verilog/majority_voter.sv
// Three lanes only, and with all three lanes different it passes lane 0 through and reports the error as uncorrectable
`timescale 1ns/1ps

module majority_voter #(
	parameter type payload_t = logic [31:0]
) (
	input  payload_t [2:0] lane_i,
	output payload_t       voted_o,
	output logic [2:0]     lane_err_o,
	output logic           err_detected_o,
	output logic           err_corrected_o
);

	// pairwise agreement
	logic eq_01;
	logic eq_02;
	logic eq_12;
	// lanes that carry the voted value
	logic [2:0] lane_match;

	assign eq_01 = (lane_i[0] == lane_i[1]);
	assign eq_02 = (lane_i[0] == lane_i[2]);
	assign eq_12 = (lane_i[1] == lane_i[2]);

	always_comb begin
		voted_o         = lane_i[0];
		lane_err_o      = 3'b000;
		err_detected_o  = 1'b0;
		err_corrected_o = 1'b0;
		if (eq_01 && eq_02) begin
			// all lanes agree
			voted_o = lane_i[0];
		end else if (eq_01) begin
			// lane 2 is the odd one
			lane_err_o      = 3'b100;
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
		end else if (eq_02) begin
			// lane 1 is the odd one
			lane_err_o      = 3'b010;
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
		end else if (eq_12) begin
			// lane 0 is the odd one so lane 1 wins
			voted_o         = lane_i[1];
			lane_err_o      = 3'b001;
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
		end else begin
			// no majority
			lane_err_o     = 3'b111;
			err_detected_o = 1'b1;
		end
	end

	assign lane_match[0] = (voted_o == lane_i[0]);
	assign lane_match[1] = (voted_o == lane_i[1]);
	assign lane_match[2] = (voted_o == lane_i[2]);

	// correction implies detection and exactly two lanes behind the output
	always_comb begin
		a_corrected_implies_detected: assert (!err_corrected_o
			|| (err_detected_o && ($countones(lane_match) == 2)))
			else $error("voter reports corrected without detected or without a majority");
	end

endmodule

// File: verilog/fault_tracker.sv
// One counter per replica that never decays, so scattered transient errors also end in a permanent-fault flag
`timescale 1ns/1ps

module fault_tracker #(
	parameter int unsigned ERR_THRESHOLD = 4
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic [ft_alu_pkg::NUM_REPLICAS-1:0] replica_err_i,
	output logic [ft_alu_pkg::NUM_REPLICAS-1:0] permanent_faulty_o,
	output logic [ft_alu_pkg::NUM_REPLICAS-1:0] perf_fault_event_o
);

	import ft_alu_pkg::*;

	// wide enough to hold the threshold itself
	localparam int unsigned CNT_W = $clog2(ERR_THRESHOLD + 1);

	logic [CNT_W-1:0]        err_cnt_q [NUM_REPLICAS];
	// counter is about to hit the threshold this edge
	logic [NUM_REPLICAS-1:0] reach_d;
	logic [NUM_REPLICAS-1:0] faulty_q;
	logic [NUM_REPLICAS-1:0] event_q;

	////////////////////////////////////////////////////////////
	// error counters
	////////////////////////////////////////////////////////////

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : g_cnt
		assign reach_d[r] = replica_err_i[r]
		                  && (err_cnt_q[r] == CNT_W'(ERR_THRESHOLD - 1));

		// saturate at the threshold
		always_ff @(posedge clk) begin
			if (!rst_n_i) begin
				err_cnt_q[r] <= '0;
			end else if (replica_err_i[r] && (err_cnt_q[r] != CNT_W'(ERR_THRESHOLD))) begin
				err_cnt_q[r] <= err_cnt_q[r] + 1'b1;
			end
		end

		// the pulse lines up with the rising flag
		a_event_on_first_rise: assert property (
			@(posedge clk) disable iff (!rst_n_i)
			perf_fault_event_o[r] == $rose(permanent_faulty_o[r])
		) else $error("fault event pulse not aligned with flag rise");
	end

	////////////////////////////////////////////////////////////
	// sticky flags and event pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			faulty_q <= '0;
			event_q  <= '0;
		end else begin
			faulty_q <= faulty_q | reach_d;
			// one cycle only, on the first crossing
			event_q  <= reach_d & ~faulty_q;
		end
	end

	assign permanent_faulty_o = faulty_q;
	assign perf_fault_event_o = event_q;

endmodule

// File: verilog/ft_alu_top.sv
// One cycle latency with no back-pressure, and a spare selector change takes effect on the error mapping in the same cycle
`timescale 1ns/1ps

module ft_alu_top #(
	parameter int unsigned ERR_THRESHOLD = 4
) (
	input  logic                                                clk,
	input  logic                                                rst_n_i,
	input  ft_alu_pkg::alu_req_t [ft_alu_pkg::NUM_REPLICAS-1:0] req_i,
	input  ft_alu_pkg::spare_sel_t                              spare_sel_i,
	output logic [ft_alu_pkg::XLEN-1:0]                         result_o,
	output logic                                                comparison_result_o,
	output logic                                                valid_o,
	output logic                                                err_detected_o,
	output logic                                                err_corrected_o,
	output logic [ft_alu_pkg::NUM_REPLICAS-1:0]                 permanent_faulty_o,
	output logic [ft_alu_pkg::NUM_REPLICAS-1:0]                 perf_fault_event_o
);

	import ft_alu_pkg::*;

	// replica and lane outputs
	alu_out_t [NUM_REPLICAS-1:0]        replica_out;
	alu_out_t [NUM_LANES-1:0]           lane_out;
	// lane fields split for the two voters
	logic [NUM_LANES-1:0][XLEN-1:0]     lane_result;
	alu_flags_t [NUM_LANES-1:0]         lane_flags;
	alu_flags_t                         voted_flags;
	// voter status
	logic [NUM_LANES-1:0]               res_lane_err;
	logic [NUM_LANES-1:0]               flg_lane_err;
	logic [NUM_LANES-1:0]               lane_err;
	logic                               res_detected;
	logic                               res_corrected;
	logic                               flg_detected;
	logic                               flg_corrected;
	// some voter saw three different lanes
	logic                               uncorrectable;
	logic [NUM_REPLICAS-1:0]            replica_err;

	////////////////////////////////////////////////////////////
	// replicas and lane selection
	////////////////////////////////////////////////////////////

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : g_replica
		alu_replica u_replica (
			.clk     (clk),
			.rst_n_i (rst_n_i),
			.req_i   (req_i[r]),
			.out_o   (replica_out[r])
		);
	end

	replica_select u_select (
		.replica_out_i (replica_out),
		.spare_sel_i   (spare_sel_i),
		.lane_err_i    (lane_err),
		.lane_out_o    (lane_out),
		.replica_err_o (replica_err)
	);

	for (genvar k = 0; k < NUM_LANES; k++) begin : g_split
		assign lane_result[k] = lane_out[k].result;
		assign lane_flags[k]  = lane_out[k].flags;
	end

	////////////////////////////////////////////////////////////
	// voting
	////////////////////////////////////////////////////////////

	majority_voter #(.payload_t(logic [XLEN-1:0])) u_result_voter (
		.lane_i          (lane_result),
		.voted_o         (result_o),
		.lane_err_o      (res_lane_err),
		.err_detected_o  (res_detected),
		.err_corrected_o (res_corrected)
	);

	majority_voter #(.payload_t(alu_flags_t)) u_flags_voter (
		.lane_i          (lane_flags),
		.voted_o         (voted_flags),
		.lane_err_o      (flg_lane_err),
		.err_detected_o  (flg_detected),
		.err_corrected_o (flg_corrected)
	);

	assign comparison_result_o = voted_flags.cmp;
	assign valid_o             = voted_flags.valid;

	// a lane is blamed if either voter flags it
	assign lane_err      = res_lane_err | flg_lane_err;
	assign uncorrectable = (res_detected && !res_corrected) || (flg_detected && !flg_corrected);
	assign err_detected_o  = res_detected || flg_detected;
	assign err_corrected_o = (res_corrected || flg_corrected) && !uncorrectable;

	////////////////////////////////////////////////////////////
	// fault tracking
	////////////////////////////////////////////////////////////

	fault_tracker #(.ERR_THRESHOLD(ERR_THRESHOLD)) u_tracker (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.replica_err_i      (replica_err),
		.permanent_faulty_o (permanent_faulty_o),
		.perf_fault_event_o (perf_fault_event_o)
	);

endmodule

// File: verif/ft_alu_checker.sv
// Assumes outputs are sampled at the rising edge and that replica requests use only the ten defined opcodes
`timescale 1ns/1ps

module ft_alu_checker #(
	parameter int unsigned ERR_THRESHOLD = 4
) (
	input  logic                                                clk,
	input  logic                                                rst_n_i,
	input  ft_alu_pkg::alu_req_t [ft_alu_pkg::NUM_REPLICAS-1:0] req_i,
	input  ft_alu_pkg::spare_sel_t                              spare_sel_i,
	input  logic [ft_alu_pkg::XLEN-1:0]                         result_i,
	input  logic                                                comparison_result_i,
	input  logic                                                valid_i,
	input  logic                                                err_detected_i,
	input  logic                                                err_corrected_i,
	input  logic [ft_alu_pkg::NUM_REPLICAS-1:0]                 permanent_faulty_i,
	input  logic [ft_alu_pkg::NUM_REPLICAS-1:0]                 perf_fault_event_i,
	output int                                                  error_count_o,
	output int                                                  check_count_o
);

	import ft_alu_pkg::*;

	// reference outputs of the requests seen at the last edge
	alu_out_t [NUM_REPLICAS-1:0] held;
	// counter model per replica
	int unsigned                 err_cnt [NUM_REPLICAS];
	logic [NUM_REPLICAS-1:0]     faulty;
	logic [NUM_REPLICAS-1:0]     pulse;
	int                          error_count = 0;
	int                          check_count = 0;

	assign error_count_o = error_count;
	assign check_count_o = check_count;

	////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////

	function automatic alu_out_t ref_alu(input alu_req_t r);
		alu_out_t o;
		logic     lt_s;
		logic     lt_u;
		o    = '0;
		lt_s = $signed(r.operand_a) < $signed(r.operand_b);
		lt_u = r.operand_a < r.operand_b;
		// a disabled replica reads as all zero
		if (r.enable) begin
			o.flags.valid = 1'b1;
			o.flags.cmp   = (r.operand_a == r.operand_b);
			case (r.op)
				ALU_ADD: o.result = r.operand_a + r.operand_b;
				ALU_SUB: o.result = r.operand_a - r.operand_b;
				ALU_AND: o.result = r.operand_a & r.operand_b;
				ALU_OR:  o.result = r.operand_a | r.operand_b;
				ALU_XOR: o.result = r.operand_a ^ r.operand_b;
				ALU_SLL: o.result = r.operand_a << r.operand_b[4:0];
				ALU_SRL: o.result = r.operand_a >> r.operand_b[4:0];
				ALU_SRA: o.result = $unsigned($signed(r.operand_a) >>> r.operand_b[4:0]);
				ALU_SLT: begin
					o.result    = XLEN'(lt_s);
					o.flags.cmp = lt_s;
				end
				ALU_SLTU: begin
					o.result    = XLEN'(lt_u);
					o.flags.cmp = lt_u;
				end
				default: o.result = '0;
			endcase
		end
		return o;
	endfunction

	// two-of-three wins, no majority keeps lane 0
	function automatic void majority_vote(input logic [XLEN-1:0] l0, input logic [XLEN-1:0] l1,
			input logic [XLEN-1:0] l2, output logic [XLEN-1:0] v, output logic [2:0] bad,
			output logic unc);
		v   = l0;
		bad = 3'b000;
		unc = 1'b0;
		if (l0 == l1) begin
			if (l1 != l2) begin
				bad = 3'b100;
			end
		end else if (l0 == l2) begin
			bad = 3'b010;
		end else if (l1 == l2) begin
			v   = l1;
			bad = 3'b001;
		end else begin
			bad = 3'b111;
			unc = 1'b1;
		end
	endfunction

	task automatic compare_field(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin : compare
		alu_out_t [NUM_LANES-1:0] lane;
		logic [XLEN-1:0]          v_res;
		logic [XLEN-1:0]          v_flg;
		logic [2:0]               bad_res;
		logic [2:0]               bad_flg;
		logic                     unc_res;
		logic                     unc_flg;
		logic                     exp_det;
		logic                     exp_cor;
		alu_flags_t               exp_flags;
		logic [NUM_REPLICAS-1:0]  rep_err;
		if (!rst_n_i) begin
			held   = '0;
			faulty = '0;
			pulse  = '0;
			for (int r = 0; r < NUM_REPLICAS; r++) begin
				err_cnt[r] = 0;
			end
		end else begin
			// lane k reads replica k unless the spare stands in
			for (int k = 0; k < NUM_LANES; k++) begin
				lane[k] = (int'(spare_sel_i) == k + 1) ? held[NUM_REPLICAS-1] : held[k];
			end
			majority_vote(lane[0].result, lane[1].result, lane[2].result, v_res, bad_res, unc_res);
			majority_vote(XLEN'(lane[0].flags), XLEN'(lane[1].flags), XLEN'(lane[2].flags),
				v_flg, bad_flg, unc_flg);
			exp_flags = alu_flags_t'(v_flg[1:0]);
			exp_det   = (bad_res != 3'b000) || (bad_flg != 3'b000);
			exp_cor   = exp_det && !(unc_res || unc_flg);
			compare_field("result_o", result_i, v_res);
			compare_field("comparison_result_o", XLEN'(comparison_result_i), XLEN'(exp_flags.cmp));
			compare_field("valid_o", XLEN'(valid_i), XLEN'(exp_flags.valid));
			compare_field("err_detected_o", XLEN'(err_detected_i), XLEN'(exp_det));
			compare_field("err_corrected_o", XLEN'(err_corrected_i), XLEN'(exp_cor));
			compare_field("permanent_faulty_o", XLEN'(permanent_faulty_i), XLEN'(faulty));
			compare_field("perf_fault_event_o", XLEN'(perf_fault_event_i), XLEN'(pulse));
			// blame goes back along the same lane map
			rep_err = '0;
			for (int k = 0; k < NUM_LANES; k++) begin
				if (int'(spare_sel_i) == k + 1) begin
					rep_err[NUM_REPLICAS-1] = bad_res[k] | bad_flg[k];
				end else begin
					rep_err[k] = bad_res[k] | bad_flg[k];
				end
			end
			// flag and pulse on the edge where a counter first hits the threshold
			pulse = '0;
			for (int r = 0; r < NUM_REPLICAS; r++) begin
				if (rep_err[r] && err_cnt[r] < ERR_THRESHOLD) begin
					err_cnt[r] = err_cnt[r] + 1;
					if (err_cnt[r] == ERR_THRESHOLD) begin
						faulty[r] = 1'b1;
						pulse[r]  = 1'b1;
					end
				end
			end
			for (int r = 0; r < NUM_REPLICAS; r++) begin
				held[r] = ref_alu(req_i[r]);
			end
		end
	end

endmodule

// File: verif/ft_alu_tb.sv
// Stimulus changes on the falling edge only; fault phases use ADD so corrupted replicas always disagree
`timescale 1ns/1ps

module ft_alu_tb;

	import ft_alu_pkg::*;

	// vectors per phase
	localparam int N_RANDOM   = 200;
	localparam int N_SINGLE   = 20;
	localparam int N_DOUBLE   = 20;
	localparam int N_PERM     = 8;
	localparam int N_SPARE    = 20;
	localparam int N_TOTAL    = N_RANDOM + N_SINGLE + N_DOUBLE + N_PERM + N_SPARE;
	localparam int MAX_CYCLES = 4 * N_TOTAL + 50;

	logic                          clk;
	logic                          rst_n;
	alu_req_t [NUM_REPLICAS-1:0]   req;
	spare_sel_t                    spare_sel;
	logic [XLEN-1:0]               result;
	logic                          cmp_res;
	logic                          valid;
	logic                          err_det;
	logic                          err_cor;
	logic [NUM_REPLICAS-1:0]       faulty;
	logic [NUM_REPLICAS-1:0]       fault_event;
	int                            chk_errors;
	int                            chk_checks;
	int                            tb_errors   = 0;
	int                            cycle_count = 0;

	ft_alu_top #(.ERR_THRESHOLD(4)) dut (
		.clk                 (clk),
		.rst_n_i             (rst_n),
		.req_i               (req),
		.spare_sel_i         (spare_sel),
		.result_o            (result),
		.comparison_result_o (cmp_res),
		.valid_o             (valid),
		.err_detected_o      (err_det),
		.err_corrected_o     (err_cor),
		.permanent_faulty_o  (faulty),
		.perf_fault_event_o  (fault_event)
	);

	ft_alu_checker #(.ERR_THRESHOLD(4)) u_checker (
		.clk                 (clk),
		.rst_n_i             (rst_n),
		.req_i               (req),
		.spare_sel_i         (spare_sel),
		.result_i            (result),
		.comparison_result_i (cmp_res),
		.valid_i             (valid),
		.err_detected_i      (err_det),
		.err_corrected_i     (err_cor),
		.permanent_faulty_i  (faulty),
		.perf_fault_event_i  (fault_event),
		.error_count_o       (chk_errors),
		.check_count_o       (chk_checks)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// hard stop if the sequence stalls
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic apply_reset(input spare_sel_t sel);
		@(negedge clk);
		rst_n     = 1'b0;
		req       = '0;
		spare_sel = sel;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic random_request(output alu_req_t r);
		logic [3:0] op_code;
		op_code     = 4'($urandom_range(0, 9));
		r.enable    = 1'b1;
		r.op        = alu_op_e'(op_code);
		r.operand_a = $urandom();
		r.operand_b = $urandom();
		// equal operands now and then for the cmp flag
		if ($urandom_range(0, 7) == 0) begin
			r.operand_b = r.operand_a;
		end
	endtask

	task automatic drive(input alu_req_t base, input logic [NUM_REPLICAS-1:0] corrupt);
		@(negedge clk);
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			req[r] = base;
			// offset differs per replica so corrupted sums stay apart
			if (corrupt[r]) begin
				req[r].operand_a = base.operand_a + XLEN'(r + 1);
			end
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			req = '0;
		end
	endtask

	task automatic expect_faulty(input logic [NUM_REPLICAS-1:0] exp);
		if (faulty !== exp) begin
			tb_errors++;
			$display("Error at %0t: permanent_faulty_o is %b, expected %b", $time, faulty, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		alu_req_t                base;
		logic [NUM_REPLICAS-1:0] corrupt;
		rst_n     = 1'b0;
		req       = '0;
		spare_sel = '0;
		void'($urandom(32'h7464));
		// identical copies, no spare
		apply_reset(2'd0);
		repeat (N_RANDOM) begin
			random_request(base);
			drive(base, '0);
		end
		idle(2);
		// one voting replica off
		apply_reset(2'd0);
		repeat (N_SINGLE) begin
			random_request(base);
			base.op = ALU_ADD;
			corrupt = 4'b0001 << $urandom_range(0, 2);
			drive(base, corrupt);
		end
		// two voting replicas off, no majority
		repeat (N_DOUBLE) begin
			random_request(base);
			base.op = ALU_ADD;
			corrupt = 4'b0111 & ~(4'b0001 << $urandom_range(0, 2));
			drive(base, corrupt);
		end
		idle(2);
		// replica 1 reaches the threshold
		apply_reset(2'd0);
		repeat (N_PERM / 2) begin
			random_request(base);
			base.op = ALU_ADD;
			drive(base, 4'b0010);
		end
		idle(N_PERM / 2);
		expect_faulty(4'b0010);
		// spare on lane 1, replica 1 drops out of the vote
		apply_reset(2'd2);
		repeat (N_SPARE / 2) begin
			random_request(base);
			base.op = ALU_ADD;
			drive(base, 4'b0010);
		end
		repeat (N_SPARE / 2) begin
			random_request(base);
			base.op = ALU_ADD;
			drive(base, 4'b1000);
		end
		idle(3);
		expect_faulty(4'b1000);
		$display("checks: %0d, checker errors: %0d, flag errors: %0d",
			chk_checks, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: sim.f
verilog/ft_alu_pkg.sv
verilog/alu_replica.sv
verilog/replica_select.sv
verilog/majority_voter.sv
verilog/fault_tracker.sv
verilog/ft_alu_top.sv
verif/ft_alu_checker.sv
verif/ft_alu_tb.sv

// File: Makefile
# Verilator build and run for the fault-tolerant ALU stage

VERILATOR ?= verilator
TOP       ?= ft_alu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
